/* regReadStage.f */
+incdir+tb
verilog/coreCfgPkg.sv
verilog/regReadPkg.sv
verilog/issueCapture.sv
verilog/physRegFile.sv
verilog/operandBypass.sv
verilog/regReadyTable.sv
verilog/regReadStage.sv
tb/regReadStageTb.sv

/* Bender.yml */
package:
  name: regReadStage

sources:
  - files:
      - verilog/coreCfgPkg.sv
      - verilog/regReadPkg.sv
      - verilog/issueCapture.sv
      - verilog/physRegFile.sv
      - verilog/operandBypass.sv
      - verilog/regReadyTable.sv
      - verilog/regReadStage.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/regReadStageTb.sv

/* tb/regReadTasks.svh */
// Register-read stage testbench tasks
// Stimulus helpers, typed compare tasks and the directed tests. Every
// test starts and ends just after a rising edge; outputs are sampled
// at the falling edge.

`ifndef REG_READ_TASKS_SVH
`define REG_READ_TASKS_SVH

function automatic logic [NUM_PHYS_REGS-1:0] archPattern();
  logic [NUM_PHYS_REGS-1:0] rdy;
  rdy = '0;
  for (int r = 0; r < NUM_ARCH_REGS; r++) begin
    rdy[r] = 1'b1;
  end
  return rdy;
endfunction

function automatic issuePkt_t makeIssue(input logic [NUM_CHECKPOINTS-1:0] mask,
                                        input int src1, input int src2, input int dest);
  issuePkt_t pkt;
  pkt.valid = 1'b1;
  pkt.brMask = mask;
  pkt.src1 = physTag_t'(src1);
  pkt.src2 = physTag_t'(src2);
  pkt.dest = physTag_t'(dest);
  pkt.instTag = INST_TAG_W'($urandom());
  return pkt;
endfunction

function automatic tagStrobe_t makeStrobe(input int tag);
  tagStrobe_t s;
  s.valid = 1'b1;
  s.tag = physTag_t'(tag);
  return s;
endfunction

function automatic execPkt_t expectedExec(input issuePkt_t pkt, input logic valid,
                                          input regData_t d1, input regData_t d2);
  execPkt_t want;
  want.pkt = pkt;
  want.pkt.valid = valid;
  want.data1 = d1;
  want.data2 = d2;
  return want;
endfunction

task automatic clearInputs();
  issue = '0;
  bypass = '0;
  wakeup = '0;
  unmap = '0;
  branch = '0;
  recoverFlag = 1'b0;
  exceptionFlag = 1'b0;
endtask

task automatic driveBypass(input int lane, input int tag, input regData_t data);
  bypass[lane].valid = 1'b1;
  bypass[lane].dest = physTag_t'(tag);
  bypass[lane].data = data;
endtask

// model the file write of the coming edge, then move past it
task automatic stepCycle();
  if (!recoverFlag) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (bypass[l].valid) begin
        refMem[bypass[l].dest] = bypass[l].data;  // higher lane applied last
      end
    end
  end
  @(posedge clk);
  #DRIVE_DLY;
endtask

task automatic issueBoth(input issuePkt_t p0, input issuePkt_t p1);
  issue[0] = p0;
  issue[1] = p1;
  stepCycle();
  issue = '0;
endtask

task automatic checkExec(input string name, input execPkt_t got, input execPkt_t want);
  logic bad;
  bad = want.pkt.valid ? (got !== want) : (got.pkt.valid !== 1'b0);  // idle slot payload is free
  if (bad) begin
    execErrors++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
  end
endtask

task automatic checkReady(input string name, input logic [NUM_PHYS_REGS-1:0] got,
                          input logic [NUM_PHYS_REGS-1:0] want);
  if (got !== want) begin
    readyErrors++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
  end
endtask

task automatic resetState();
  @(negedge clk);
  checkReady("phyRegRdy_o", phyRegRdy, archPattern());
  for (int l = 0; l < NUM_LANES; l++) begin
    checkExec($sformatf("exec_o[%0d]", l), exec[l], '0);
  end
  stepCycle();
endtask

task automatic registerRead();
  issuePkt_t p0;
  issuePkt_t p1;
  for (int r = 40; r < 48; r += 2) begin  // two fresh registers per cycle
    driveBypass(0, r, $urandom());
    driveBypass(1, r + 1, $urandom());
    stepCycle();
  end
  bypass = '0;
  for (int r = 40; r < 48; r += 4) begin
    p0 = makeIssue('0, r, r + 1, 10);
    p1 = makeIssue('0, r + 3, r + 2, 11);
    issueBoth(p0, p1);
    @(negedge clk);
    checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b1, refMem[r], refMem[r + 1]));
    checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, refMem[r + 3], refMem[r + 2]));
    stepCycle();
  end
endtask

task automatic operandForwarding();
  issuePkt_t p0;
  issuePkt_t p1;
  regData_t fwd;
  regData_t fwdLo;
  regData_t oldVal;
  regData_t hiVal;
  p0 = makeIssue('0, 40, 41, 12);
  p1 = makeIssue('0, 42, 44, 13);
  issueBoth(p0, p1);
  fwd = $urandom();
  fwdLo = $urandom();
  driveBypass(0, 42, fwdLo);  // single writer of lane 1 src1
  driveBypass(1, 41, fwd);  // single writer of lane 0 src2
  @(negedge clk);
  checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b1, refMem[40], fwd));
  checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, fwdLo, refMem[44]));
  stepCycle();
  bypass = '0;

  p0 = makeIssue('0, 42, 43, 12);
  p1 = makeIssue('0, 45, 42, 13);
  issueBoth(p0, p1);
  oldVal = refMem[42];
  hiVal = $urandom();
  driveBypass(0, 42, ~hiVal);  // both lanes hit tag 42
  driveBypass(1, 42, hiVal);
  @(negedge clk);
  checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b1, oldVal, refMem[43]));
  checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, refMem[45], oldVal));
  stepCycle();
  bypass = '0;

  p0 = makeIssue('0, 42, 42, 14);
  p1 = makeIssue('0, 41, 40, 15);
  issueBoth(p0, p1);
  @(negedge clk);
  checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b1, hiVal, hiVal));
  checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, fwd, refMem[40]));
  stepCycle();
endtask

task automatic branchSquash();
  issuePkt_t p0;
  issuePkt_t p1;
  p0 = makeIssue(4'b0100, 40, 41, 16);
  p1 = makeIssue(4'b0001, 43, 44, 17);
  branch.verified = 1'b1;
  branch.mispredict = 1'b1;
  branch.chkptId = 2'd2;
  issueBoth(p0, p1);
  branch = '0;
  @(negedge clk);
  checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b0, refMem[40], refMem[41]));
  checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, refMem[43], refMem[44]));
  stepCycle();

  branch.mispredict = 1'b1;  // not yet verified
  branch.chkptId = 2'd2;
  issueBoth(p0, p1);
  branch = '0;
  @(negedge clk);
  checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b1, refMem[40], refMem[41]));
  checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, refMem[43], refMem[44]));
  stepCycle();
endtask

task automatic recoveryBlock();
  issuePkt_t p0;
  issuePkt_t p1;
  regData_t old45;
  regData_t old46;
  old45 = refMem[45];
  old46 = refMem[46];
  recoverFlag = 1'b1;
  driveBypass(0, 45, ~old45);
  driveBypass(1, 46, ~old46);
  stepCycle();
  recoverFlag = 1'b0;
  bypass = '0;
  p0 = makeIssue('0, 45, 46, 18);
  p1 = makeIssue('0, 46, 45, 19);
  issueBoth(p0, p1);
  @(negedge clk);
  checkExec("exec_o[0]", exec[0], expectedExec(p0, 1'b1, old45, old46));
  checkExec("exec_o[1]", exec[1], expectedExec(p1, 1'b1, old46, old45));
  stepCycle();
endtask

task automatic readyTracking();
  logic [NUM_PHYS_REGS-1:0] expRdy;
  expRdy = archPattern();
  unmap[0] = makeStrobe(5);
  unmap[1] = makeStrobe(20);
  stepCycle();
  unmap = '0;
  @(negedge clk);
  expRdy[5] = 1'b0;
  expRdy[20] = 1'b0;
  checkReady("phyRegRdy_o", phyRegRdy, expRdy);
  stepCycle();

  wakeup[0] = makeStrobe(5);
  stepCycle();
  wakeup = '0;
  @(negedge clk);
  expRdy[5] = 1'b1;
  checkReady("phyRegRdy_o", phyRegRdy, expRdy);
  stepCycle();

  unmap[0] = makeStrobe(50);  // same register unmapped and woken
  wakeup[1] = makeStrobe(50);
  unmap[1] = makeStrobe(20);
  wakeup[0] = makeStrobe(20);
  stepCycle();
  unmap = '0;
  wakeup = '0;
  @(negedge clk);
  expRdy[50] = 1'b1;
  expRdy[20] = 1'b1;
  checkReady("phyRegRdy_o", phyRegRdy, expRdy);
  stepCycle();

  exceptionFlag = 1'b1;
  wakeup[1] = makeStrobe(60);
  stepCycle();
  exceptionFlag = 1'b0;
  wakeup = '0;
  @(negedge clk);
  checkReady("phyRegRdy_o", phyRegRdy, archPattern());
  stepCycle();
endtask

`endif

/* tb/regReadStageTb.sv */
// Register-read stage testbench
// Directed tests for operand read, forwarding, squash, recovery and the
// ready table, checked against a small model of the register file.

`timescale 1ns/1ps

module regReadStageTb;

  import coreCfgPkg::*;
  import regReadPkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY = 2;
  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES = 64;  // upper bound of the directed sequence
  localparam int MARGIN_CYCLES = 100;
  localparam int SEED = 32'hcf1d;

  logic clk;
  logic rstN;
  issuePkt_t [NUM_LANES-1:0] issue;
  bypassPkt_t [NUM_LANES-1:0] bypass;
  tagStrobe_t [NUM_LANES-1:0] wakeup;
  tagStrobe_t [NUM_LANES-1:0] unmap;
  branchResolve_t branch;
  logic recoverFlag;
  logic exceptionFlag;
  execPkt_t [NUM_LANES-1:0] exec;
  logic [NUM_PHYS_REGS-1:0] phyRegRdy;

  regData_t refMem [NUM_PHYS_REGS];  // expected register file contents
  int execErrors;
  int readyErrors;

  `include "regReadTasks.svh"

  regReadStage i_dut (
    .clk             (clk),
    .rstN_i          (rstN),
    .issue_i         (issue),
    .bypass_i        (bypass),
    .wakeup_i        (wakeup),
    .unmap_i         (unmap),
    .branch_i        (branch),
    .recoverFlag_i   (recoverFlag),
    .exceptionFlag_i (exceptionFlag),
    .exec_o          (exec),
    .phyRegRdy_o     (phyRegRdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    execErrors = 0;
    readyErrors = 0;
    rstN = 1'b0;
    clearInputs();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rstN = 1'b1;

    resetState();
    registerRead();
    operandForwarding();
    branchSquash();
    recoveryBlock();
    readyTracking();

    $display("run complete: %0d exec errors, %0d ready errors", execErrors, readyErrors);
    if (execErrors + readyErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/regReadStage.sv */
// Register-read stage
// Captures issued instructions, reads their sources from the physical
// register file, forwards same-cycle results and tracks register
// readiness for wakeup. One cycle from issue to execute.

`timescale 1ns/1ps

module regReadStage (
  input  logic                                                      clk,
  input  logic                                                      rstN_i,
  input  regReadPkg::issuePkt_t      [coreCfgPkg::NUM_LANES-1:0]    issue_i,
  input  regReadPkg::bypassPkt_t     [coreCfgPkg::NUM_LANES-1:0]    bypass_i,
  input  regReadPkg::tagStrobe_t     [coreCfgPkg::NUM_LANES-1:0]    wakeup_i,
  input  regReadPkg::tagStrobe_t     [coreCfgPkg::NUM_LANES-1:0]    unmap_i,
  input  regReadPkg::branchResolve_t                                branch_i,
  input  logic                                                      recoverFlag_i,
  input  logic                                                      exceptionFlag_i,
  output regReadPkg::execPkt_t       [coreCfgPkg::NUM_LANES-1:0]    exec_o,
  output logic                       [coreCfgPkg::NUM_PHYS_REGS-1:0] phyRegRdy_o
);

  import coreCfgPkg::*;
  import regReadPkg::*;

  issuePkt_t [NUM_LANES-1:0]      capPkt;
  physTag_t  [NUM_LANES-1:0][1:0] rdTag;
  regData_t  [NUM_LANES-1:0][1:0] readData;

  for (genvar l = 0; l < NUM_LANES; l++) begin : gTag
    assign rdTag[l][0] = capPkt[l].src1;
    assign rdTag[l][1] = capPkt[l].src2;
  end

  issueCapture uCapture (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .issue_i  (issue_i),
    .branch_i (branch_i),
    .capPkt_o (capPkt)
  );

  physRegFile uRegFile (
    .clk           (clk),
    .recoverFlag_i (recoverFlag_i),
    .write_i       (bypass_i),
    .rdTag_i       (rdTag),
    .rdData_o      (readData)
  );

  operandBypass uBypass (
    .capPkt_i (capPkt),
    .rdData_i (readData),
    .bypass_i (bypass_i),
    .exec_o   (exec_o)
  );

  regReadyTable uReady (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .exceptionFlag_i (exceptionFlag_i),
    .wakeup_i        (wakeup_i),
    .unmap_i         (unmap_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

/* verilog/regReadyTable.sv */
// Physical register ready table
// One ready bit per physical register for issue wakeup. Unmap clears a
// bit, wakeup sets it, and an exception reloads the architectural map.

`timescale 1ns/1ps

module regReadyTable (
  input  logic                                                  clk,
  input  logic                                                  rstN_i,
  input  logic                                                  exceptionFlag_i,
  input  regReadPkg::tagStrobe_t [coreCfgPkg::NUM_LANES-1:0]    wakeup_i,
  input  regReadPkg::tagStrobe_t [coreCfgPkg::NUM_LANES-1:0]    unmap_i,
  output logic [coreCfgPkg::NUM_PHYS_REGS-1:0]                  phyRegRdy_o
);

  import coreCfgPkg::*;

  logic [NUM_PHYS_REGS-1:0] rdyQ;
  logic [NUM_PHYS_REGS-1:0] rdyNext;

  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmap_i[l].valid) begin
        rdyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    // applied last so a wakeup beats an unmap of the same register
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeup_i[l].valid) begin
        rdyNext[wakeup_i[l].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      rdyQ <= ARCH_RDY_MASK;
    end else if (exceptionFlag_i) begin
      rdyQ <= ARCH_RDY_MASK;  // back to the committed map
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

/* verilog/operandBypass.sv */
// Operand bypass network
// Picks each source operand from the result buses or the register file.
// A bus only forwards when it is the single lane writing that source
// tag this cycle; otherwise the register file value is used. Assembles
// the execute packets.

`timescale 1ns/1ps

module operandBypass (
  input  regReadPkg::issuePkt_t  [coreCfgPkg::NUM_LANES-1:0]        capPkt_i,
  input  regReadPkg::regData_t   [coreCfgPkg::NUM_LANES-1:0][1:0]   rdData_i,
  input  regReadPkg::bypassPkt_t [coreCfgPkg::NUM_LANES-1:0]        bypass_i,
  output regReadPkg::execPkt_t   [coreCfgPkg::NUM_LANES-1:0]        exec_o
);

  import coreCfgPkg::*;
  import regReadPkg::*;

  logic [NUM_LANES-1:0] src1Match [NUM_LANES];
  logic [NUM_LANES-1:0] src2Match [NUM_LANES];

  function automatic logic [NUM_LANES-1:0] matchVec(input physTag_t srcTag,
                                                    input bypassPkt_t [NUM_LANES-1:0] byp);
    logic [NUM_LANES-1:0] hit;
    for (int b = 0; b < NUM_LANES; b++) begin
      hit[b] = byp[b].valid && (byp[b].dest == srcTag);
    end
    return hit;
  endfunction

  function automatic regData_t pickOperand(input logic [NUM_LANES-1:0] hit,
                                           input regData_t rfData,
                                           input bypassPkt_t [NUM_LANES-1:0] byp);
    regData_t operand;
    operand = rfData;
    // exactly one hit, else fall back to the file
    if ((hit != '0) && ((hit & (hit - 1'b1)) == '0)) begin
      for (int b = 0; b < NUM_LANES; b++) begin
        if (hit[b]) begin
          operand = byp[b].data;
        end
      end
    end
    return operand;
  endfunction

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      src1Match[l] = matchVec(capPkt_i[l].src1, bypass_i);
      src2Match[l] = matchVec(capPkt_i[l].src2, bypass_i);
    end
  end

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      exec_o[l].pkt   = capPkt_i[l];
      exec_o[l].data1 = pickOperand(src1Match[l], rdData_i[l][0], bypass_i);
      exec_o[l].data2 = pickOperand(src2Match[l], rdData_i[l][1], bypass_i);
    end
  end

endmodule

/* verilog/physRegFile.sv */
// Physical register file
// NUM_PHYS_REGS operand words with one write port per result lane and
// two combinational read ports per issue lane. Writes are blocked
// during branch recovery.

`timescale 1ns/1ps

module physRegFile (
  input  logic                                                      clk,
  input  logic                                                      recoverFlag_i,
  input  regReadPkg::bypassPkt_t [coreCfgPkg::NUM_LANES-1:0]        write_i,
  input  regReadPkg::physTag_t   [coreCfgPkg::NUM_LANES-1:0][1:0]   rdTag_i,
  output regReadPkg::regData_t   [coreCfgPkg::NUM_LANES-1:0][1:0]   rdData_o
);

  import coreCfgPkg::*;
  import regReadPkg::*;

  regData_t regMem [NUM_PHYS_REGS];

  // lanes are walked in order so the higher lane wins a tie
  always_ff @(posedge clk) begin
    if (!recoverFlag_i) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (write_i[l].valid) begin
          regMem[write_i[l].dest] <= write_i[l].data;
        end
      end
    end
  end

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      rdData_o[l][0] = regMem[rdTag_i[l][0]];  // src1
      rdData_o[l][1] = regMem[rdTag_i[l][1]];  // src2
    end
  end

endmodule

/* verilog/issueCapture.sv */
// Issue capture
// Input register stage of the register-read pipe. Latches one issue
// packet per lane every cycle and kills packets that sit under a
// verified mispredicted branch.

`timescale 1ns/1ps

module issueCapture (
  input  logic                                                clk,
  input  logic                                                rstN_i,
  input  regReadPkg::issuePkt_t [coreCfgPkg::NUM_LANES-1:0]   issue_i,
  input  regReadPkg::branchResolve_t                          branch_i,
  output regReadPkg::issuePkt_t [coreCfgPkg::NUM_LANES-1:0]   capPkt_o
);

  import coreCfgPkg::*;
  import regReadPkg::*;

  logic mispredictEvent;
  logic [NUM_LANES-1:0] squash;
  logic [NUM_LANES-1:0] validQ;
  issuePkt_t [NUM_LANES-1:0] pktQ;

  assign mispredictEvent = branch_i.verified & branch_i.mispredict;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      squash[l] = mispredictEvent & issue_i[l].brMask[branch_i.chkptId];
    end
  end

  // captured valid per lane
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        validQ[l] <= issue_i[l].valid & ~squash[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    pktQ <= issue_i;
  end

  always_comb begin
    capPkt_o = pktQ;
    for (int l = 0; l < NUM_LANES; l++) begin
      capPkt_o[l].valid = validQ[l];  // squash-qualified valid
    end
  end

endmodule

/* verilog/regReadPkg.sv */
// Register-read packet types
// Packed structs for the issue, bypass, wakeup/unmap, branch-resolve
// and execute packets that travel through the register-read stage.

package regReadPkg;

  import coreCfgPkg::*;

  typedef logic [PHYS_REG_W-1:0] physTag_t;
  typedef logic [DATA_W-1:0] regData_t;

  // instruction handed over by the issue queue
  typedef struct packed {
    logic valid;
    logic [NUM_CHECKPOINTS-1:0] brMask;  // unresolved branches it depends on
    physTag_t src1;
    physTag_t src2;
    physTag_t dest;
    logic [INST_TAG_W-1:0] instTag;
  } issuePkt_t;

  // result bus, one per lane
  typedef struct packed {
    logic valid;
    physTag_t dest;
    regData_t data;
  } bypassPkt_t;

  // wakeup and unmap strobes
  typedef struct packed {
    logic valid;
    physTag_t tag;
  } tagStrobe_t;

  typedef struct packed {
    logic verified;
    logic mispredict;
    logic [CHECKPOINT_W-1:0] chkptId;
  } branchResolve_t;

  // instruction with its operands, towards execute
  typedef struct packed {
    issuePkt_t pkt;
    regData_t data1;
    regData_t data2;
  } execPkt_t;

endpackage

/* verilog/coreCfgPkg.sv */
// Core configuration constants
// Sizes shared by every block of the register-read stage: lane count,
// physical register file depth, operand width and branch checkpoints.

package coreCfgPkg;

  // issue and bypass lanes
  localparam int NUM_LANES = 2;

  // physical register file
  localparam int NUM_PHYS_REGS = 64;
  localparam int PHYS_REG_W = 6;

  // registers mapped by the rename table at reset
  localparam int NUM_ARCH_REGS = 32;

  // operand width
  localparam int DATA_W = 32;

  // branch checkpoints
  localparam int NUM_CHECKPOINTS = 4;
  localparam int CHECKPOINT_W = 2;

  // opaque tag carried through the stage untouched
  localparam int INST_TAG_W = 8;

  // ready pattern after reset or an exception
  localparam logic [NUM_PHYS_REGS-1:0] ARCH_RDY_MASK =
    {{(NUM_PHYS_REGS - NUM_ARCH_REGS){1'b0}}, {NUM_ARCH_REGS{1'b1}}};

endpackage
